/* logic/conv_settings.svh */
/*
  Build-time sizes for the MAC array.
  CONV_ACC_W must be a multiple of 4 (carry-lookahead groups).
  The multiplier tree is fixed to 8-bit operands, so CONV_DATA_W stays 8.
*/
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// output channels, one MAC lane each
`define CONV_LANES 4

// signed operand width of features, weights and biases
`define CONV_DATA_W 8

// lane accumulator width
`define CONV_ACC_W 28

// fixed-point position: bias is shifted left by this, result byte is taken from here
`define CONV_FRAC_SHIFT 6

// register stages from operand capture to signed product
`define CONV_MUL_DEPTH 8

`endif

/* logic/conv_arith_pkg.sv */
/*
  Numeric types of the datapath.
  Magnitudes are unsigned so that -128 maps to 128 without overflow.
*/
`include "conv_settings.svh"

package conv_arith_pkg;

  ////////////////////////////////////////
  // operands
  ////////////////////////////////////////

  // signed feature or weight
  typedef logic signed [`CONV_DATA_W-1:0] operand_t;

  // absolute value of an operand
  typedef logic [`CONV_DATA_W-1:0] magnitude_t;

  ////////////////////////////////////////
  // results
  ////////////////////////////////////////

  // full precision product of two operands
  typedef logic signed [2*`CONV_DATA_W-1:0] product_t;

  // running dot-product sum of one lane
  typedef logic signed [`CONV_ACC_W-1:0] acc_t;

endpackage

/* logic/conv_stream_pkg.sv */
/*
  Lane vectors carried on the stream and bias ports.
  Element i belongs to lane i, element 0 sits in the lowest bits.
*/
`include "conv_settings.svh"

package conv_stream_pkg;

  // one weight per lane on every input beat
  typedef logic [`CONV_LANES-1:0][`CONV_DATA_W-1:0] weight_vec_t;

  // one signed bias per lane, applied at drain time
  typedef logic [`CONV_LANES-1:0][`CONV_DATA_W-1:0] bias_vec_t;

  // packed result bytes, byte i from lane i
  typedef logic [`CONV_LANES-1:0][7:0] out_word_t;

  // all lane accumulators side by side
  typedef logic [`CONV_LANES-1:0][`CONV_ACC_W-1:0] acc_vec_t;

endpackage

/* logic/cla_adder.sv */
/*
  Carry-lookahead adder, no carry in. W must be a multiple of 4.
  Lookahead inside each 4-bit group, group carries ripple upward.
*/
`timescale 1ns/1ps

module cla_adder #(
  parameter int W = 16
) (
  input  logic [W-1:0] a,
  input  logic [W-1:0] b,
  output logic [W-1:0] sum,
  output logic         carry_out
);
  localparam int GROUPS = W / 4;

  logic [GROUPS:0] grp_carry; // carry into each group

  assign grp_carry[0] = 1'b0;

  for (genvar g = 0; g < GROUPS; g++) begin : g_group
    logic [3:0] prop;
    logic [3:0] gen;
    logic [3:0] c;   // carry into each bit of the group
    logic       grp_p;
    logic       grp_g;

    assign prop = a[4*g +: 4] ^ b[4*g +: 4];
    assign gen  = a[4*g +: 4] & b[4*g +: 4];

    // bit carries, fully expanded from the group carry in
    assign c[0] = grp_carry[g];
    assign c[1] = gen[0] | (prop[0] & c[0]);
    assign c[2] = gen[1] | (prop[1] & gen[0]) | (prop[1] & prop[0] & c[0]);
    assign c[3] = gen[2] | (prop[2] & gen[1]) | (prop[2] & prop[1] & gen[0])
                | (prop[2] & prop[1] & prop[0] & c[0]);

    // group propagate / generate
    assign grp_p = &prop;
    assign grp_g = gen[3] | (prop[3] & gen[2]) | (prop[3] & prop[2] & gen[1])
                 | (prop[3] & prop[2] & prop[1] & gen[0]);

    assign grp_carry[g+1] = grp_g | (grp_p & c[0]); // ripple to next group
    assign sum[4*g +: 4]  = prop ^ c;
  end

  assign carry_out = grp_carry[GROUPS];

endmodule

/* logic/mac_lane.sv */
/*
  One MAC lane: sign-magnitude multiplier, 8 stages, then accumulate.
  Everything freezes while en is low. Accumulator restarts on the delayed first flag.
  The partial-product tree assumes 8-bit operands.
*/
`timescale 1ns/1ps
`include "conv_settings.svh"

module mac_lane (
  input  logic                     clk,
  input  logic                     en,
  input  conv_arith_pkg::operand_t feat,
  input  conv_arith_pkg::operand_t weight,
  input  logic                     first,
  output conv_arith_pkg::acc_t     acc
);
  localparam int D     = `CONV_MUL_DEPTH;
  localparam int ACC_W = `CONV_ACC_W;

  conv_arith_pkg::magnitude_t feat_mag;
  conv_arith_pkg::magnitude_t weight_mag;
  conv_arith_pkg::magnitude_t pp_q [8];   // stage 1, partial products
  logic [5:0]                 lo2_q [4];  // stage 2
  logic [2:0]                 hi2a_q [4];
  logic [3:0]                 hi2b_q [4];
  logic [9:0]                 pair_q [4]; // stage 3
  logic [7:0]                 lo4_q [2];  // stage 4
  logic [2:0]                 hi4a_q [2];
  logic [4:0]                 hi4b_q [2];
  logic [11:0]                quad_q [2]; // stage 5
  logic [9:0]                 lo6_q;      // stage 6
  logic [2:0]                 hi6a_q;
  logic [6:0]                 hi6b_q;
  logic [15:0]                mag_q;      // stage 7, unsigned product
  conv_arith_pkg::product_t   prod_q;     // stage 8
  logic [D-2:0]               sign_pipe;
  logic [D-1:0]               first_pipe;
  conv_arith_pkg::acc_t       prod_ext;
  conv_arith_pkg::acc_t       acc_base;
  conv_arith_pkg::acc_t       acc_next;

  // -128 gives magnitude 128, still fits unsigned
  assign feat_mag   = feat[7] ? ~feat + 1'b1 : feat;
  assign weight_mag = weight[7] ? ~weight + 1'b1 : weight;

  ////////////////////////////////////////
  // multiplier tree
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (en) begin
      for (int k = 0; k < 8; k++) begin
        pp_q[k] <= weight_mag[k] ? feat_mag : '0;
      end
      // low bits of each pair first, high bits wait a cycle
      for (int j = 0; j < 4; j++) begin
        lo2_q[j]  <= {1'b0, pp_q[2*j][4:0]} + {1'b0, pp_q[2*j+1][3:0], 1'b0};
        hi2a_q[j] <= pp_q[2*j][7:5];
        hi2b_q[j] <= pp_q[2*j+1][7:4];
        pair_q[j] <= {{2'b00, hi2a_q[j]} + {1'b0, hi2b_q[j]} + {4'd0, lo2_q[j][5]},
                      lo2_q[j][4:0]};
      end
      for (int m = 0; m < 2; m++) begin
        lo4_q[m]  <= {1'b0, pair_q[2*m][6:0]} + {1'b0, pair_q[2*m+1][4:0], 2'b00};
        hi4a_q[m] <= pair_q[2*m][9:7];
        hi4b_q[m] <= pair_q[2*m+1][9:5];
        quad_q[m] <= {{2'b00, hi4a_q[m]} + hi4b_q[m] + {4'd0, lo4_q[m][7]},
                      lo4_q[m][6:0]};
      end
      lo6_q  <= {1'b0, quad_q[0][8:0]} + {1'b0, quad_q[1][4:0], 4'd0};
      hi6a_q <= quad_q[0][11:9];
      hi6b_q <= quad_q[1][11:5];
      mag_q  <= {{4'd0, hi6a_q} + hi6b_q + {6'd0, lo6_q[9]}, lo6_q[8:0]};
      // stage 8, sign back on
      prod_q <= sign_pipe[D-2] ? ~mag_q + 1'b1 : mag_q;
      sign_pipe  <= {sign_pipe[D-3:0], feat[7] ^ weight[7]};
      first_pipe <= {first_pipe[D-2:0], first};
    end
  end

  ////////////////////////////////////////
  // accumulate
  ////////////////////////////////////////

  assign prod_ext = {{(ACC_W-16){prod_q[15]}}, prod_q};
  assign acc_base = first_pipe[D-1] ? '0 : acc; // new dot product starts from zero

  cla_adder #(.W(ACC_W)) i_acc_add (
    .a         (prod_ext),
    .b         (acc_base),
    .sum       (acc_next),
    .carry_out ()
  );

  always_ff @(posedge clk) begin
    if (en) begin
      acc <= acc_next;
    end
  end

endmodule

/* logic/operand_feeder.sv */
/*
  Input side of the array. in_ready follows advance.
  Bubbles reach the lanes as zero operands with first low.
  result_tick marks the cycle the lane sums of a finished dot product are final.
*/
`timescale 1ns/1ps
`include "conv_settings.svh"

module operand_feeder (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         in_valid,
  input  conv_arith_pkg::operand_t     in_feat,
  input  conv_stream_pkg::weight_vec_t in_weights,
  input  logic                         in_first,
  input  logic                         in_last,
  input  logic                         advance,
  output logic                         in_ready,
  output conv_arith_pkg::operand_t     lane_feat,
  output conv_stream_pkg::weight_vec_t lane_weights,
  output logic                         lane_first,
  output logic                         result_tick
);
  // multiplier stages plus the accumulate stage
  localparam int TICK_DEPTH = `CONV_MUL_DEPTH + 1;

  logic [TICK_DEPTH-1:0] tick_chain;

  assign in_ready = advance; // pipe only moves when the output side can take

  ////////////////////////////////////////
  // operands to lanes
  ////////////////////////////////////////

  // zero product on a bubble, so the sums are untouched
  assign lane_feat    = in_valid ? in_feat : '0;
  assign lane_weights = in_valid ? in_weights : '0;
  assign lane_first   = in_valid & in_first;

  ////////////////////////////////////////
  // end-of-dot-product timing
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      tick_chain <= '0;
    end else if (advance) begin
      tick_chain <= {tick_chain[TICK_DEPTH-2:0], in_valid & in_last};
    end
  end

  assign result_tick = tick_chain[TICK_DEPTH-1]; // aligned with final lane sums

endmodule

/* logic/result_packer.sv */
/*
  Drain stage: bias add, ReLU, saturation to 0..127, one byte per lane.
  Holds the word until out_ready. Biases must not change while a dot product is in flight.
  advance is the pipeline enable for the feeder and all lanes.
*/
`timescale 1ns/1ps
`include "conv_settings.svh"

module result_packer (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       result_tick,
  input  conv_stream_pkg::acc_vec_t  lane_acc,
  input  logic                       bias_we,
  input  conv_stream_pkg::bias_vec_t bias_data,
  input  logic                       out_ready,
  output logic                       out_valid,
  output conv_stream_pkg::out_word_t out_data,
  output logic                       advance
);
  localparam int LANES  = `CONV_LANES;
  localparam int ACC_W  = `CONV_ACC_W;
  localparam int DATA_W = `CONV_DATA_W;
  localparam int SHIFT  = `CONV_FRAC_SHIFT;
  localparam int EXT_W  = ACC_W - DATA_W - SHIFT;

  conv_stream_pkg::bias_vec_t bias_q;
  conv_stream_pkg::out_word_t result_word;
  conv_arith_pkg::acc_t       bias_ext [LANES];
  conv_arith_pkg::acc_t       total [LANES];

  always_ff @(posedge clk) begin
    if (bias_we) begin
      bias_q <= bias_data;
    end
  end

  ////////////////////////////////////////
  // per-lane bias add and saturate
  ////////////////////////////////////////

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    // bias lines up with the fraction point of the sum
    assign bias_ext[i] = {{EXT_W{bias_q[i][DATA_W-1]}}, bias_q[i], {SHIFT{1'b0}}};

    cla_adder #(.W(ACC_W)) i_bias_add (
      .a         (lane_acc[i]),
      .b         (bias_ext[i]),
      .sum       (total[i]),
      .carry_out ()
    );

    // negative -> 0, too large -> 127, else integer part
    assign result_word[i] = total[i][ACC_W-1] ? 8'h00 :
                            (|total[i][ACC_W-2:SHIFT+7]) ? 8'h7f :
                            {1'b0, total[i][SHIFT+6:SHIFT]};
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  assign advance = !out_valid || out_ready; // free slot or word leaving

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= result_tick;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && result_tick) begin
      out_data <= result_word; // held while the word waits
    end
  end

endmodule

/* logic/conv_mac_array.sv */
/*
  Four-lane signed MAC array with valid/ready in and out.
  Last beat to out_valid is 10 cycles without stalls. Back-pressure freezes the whole pipe.
*/
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_mac_array (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         in_valid,
  input  conv_arith_pkg::operand_t     in_feat,
  input  conv_stream_pkg::weight_vec_t in_weights,
  input  logic                         in_first,
  input  logic                         in_last,
  output logic                         in_ready,
  input  logic                         bias_we,
  input  conv_stream_pkg::bias_vec_t   bias_data,
  output logic                         out_valid,
  output conv_stream_pkg::out_word_t   out_data,
  input  logic                         out_ready
);
  conv_arith_pkg::operand_t     lane_feat;
  conv_stream_pkg::weight_vec_t lane_weights;
  logic                         lane_first;
  logic                         result_tick;
  logic                         advance;    // pipeline enable
  conv_stream_pkg::acc_vec_t    lane_acc;

  operand_feeder i_feeder (
    .clk          (clk),
    .rstn         (rstn),
    .in_valid     (in_valid),
    .in_feat      (in_feat),
    .in_weights   (in_weights),
    .in_first     (in_first),
    .in_last      (in_last),
    .advance      (advance),
    .in_ready     (in_ready),
    .lane_feat    (lane_feat),
    .lane_weights (lane_weights),
    .lane_first   (lane_first),
    .result_tick  (result_tick)
  );

  // feature is shared, each lane has its own weight
  for (genvar i = 0; i < `CONV_LANES; i++) begin : g_lane
    mac_lane i_lane (
      .clk    (clk),
      .en     (advance),
      .feat   (lane_feat),
      .weight (lane_weights[i]),
      .first  (lane_first),
      .acc    (lane_acc[i])
    );
  end

  result_packer i_packer (
    .clk         (clk),
    .rstn        (rstn),
    .result_tick (result_tick),
    .lane_acc    (lane_acc),
    .bias_we     (bias_we),
    .bias_data   (bias_data),
    .out_ready   (out_ready),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .advance     (advance)
  );

endmodule

/* tests/conv_mac_checker.sv */
/*
  Output handshake and back-pressure properties of the MAC array, bound to the top level.
  Checked only while rstn is high.
*/
`timescale 1ns/1ps

module conv_mac_checker (
  input logic                      clk,
  input logic                      rstn,
  input logic                      in_ready,
  input logic                      out_valid,
  input logic [31:0]               out_data,
  input logic                      out_ready,
  input conv_stream_pkg::acc_vec_t lane_acc
);

  // a waiting word keeps its data and its valid
  a_data_hold : assert property (@(posedge clk) disable iff (!rstn)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("out_data or out_valid changed while a word waited");

  a_valid_known : assert property (@(posedge clk) disable iff (!rstn)
    !$isunknown(out_valid))
    else $error("out_valid is unknown after reset");

  // whole pipe freezes under back-pressure
  a_stall_input : assert property (@(posedge clk) disable iff (!rstn)
    out_valid && !out_ready |-> !in_ready ##1 $stable(lane_acc))
    else $error("input taken or lane sums moved while an output word waited");

endmodule

bind conv_mac_array conv_mac_checker i_checker (
  .clk       (clk),
  .rstn      (rstn),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_data  (out_data),
  .out_ready (out_ready),
  .lane_acc  (lane_acc)
);

/* tests/conv_mac_array_tb.sv */
/*
  Table-driven testbench for the MAC array. One row is one dot product, sent in order.
  Weights rotate one byte per beat across the lanes. Biases change only on an empty pipe.
*/
`timescale 1ns/1ps

module conv_mac_array_tb;

  logic        clk = 1'b0;
  logic        rstn;
  logic        in_valid;
  logic [7:0]  in_feat;
  logic [31:0] in_weights;
  logic        in_first;
  logic        in_last;
  logic        in_ready;
  logic        bias_we;
  logic [31:0] bias_data;
  logic        out_valid;
  logic [31:0] out_data;
  logic        out_ready;

  // stimulus table
  int          row_len [16];
  logic [71:0] row_feat [16]; // beat k in byte k
  logic [31:0] row_w [16];    // lane weights of beat 0
  logic [31:0] row_bias [16];
  bit          row_rnd [16];  // random gaps and out_ready
  int          nrows = 0;
  logic [31:0] cur_bias;
  int          rcvd = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  conv_mac_array i_dut (
    .clk        (clk),
    .rstn       (rstn),
    .in_valid   (in_valid),
    .in_feat    (in_feat),
    .in_weights (in_weights),
    .in_first   (in_first),
    .in_last    (in_last),
    .in_ready   (in_ready),
    .bias_we    (bias_we),
    .bias_data  (bias_data),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ready  (out_ready)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////
  // table and reference model
  ////////////////////////////////////////

  task automatic add_row(int len, logic [71:0] feat, logic [31:0] w, logic [31:0] b, bit rnd);
    row_len[nrows]  = len;
    row_feat[nrows] = feat;
    row_w[nrows]    = w;
    row_bias[nrows] = b;
    row_rnd[nrows]  = rnd;
    nrows++;
  endtask

  function automatic logic [31:0] beat_weights(int r, int k);
    int rot;
    rot = 8 * (k % 4);
    if (rot == 0) return row_w[r];
    return (row_w[r] << rot) | (row_w[r] >> (32 - rot));
  endfunction

  // dot product plus bias * 64, then ReLU / saturate / bits 12..6
  function automatic logic [31:0] expected_word(int r);
    int               sum;
    int               total;
    logic [31:0]      w;
    logic signed [7:0] f;
    logic signed [7:0] wb;
    logic signed [7:0] b;
    logic [31:0]      word;
    word = '0;
    for (int lane = 0; lane < 4; lane++) begin
      sum = 0;
      for (int k = 0; k < row_len[r]; k++) begin
        w   = beat_weights(r, k);
        f   = row_feat[r][8*k +: 8];
        wb  = w[8*lane +: 8];
        sum = sum + int'(f) * int'(wb);
      end
      b     = row_bias[r][8*lane +: 8];
      total = sum + int'(b) * 64;
      if (total < 0) word[8*lane +: 8] = 8'd0;
      else if (total >= 8192) word[8*lane +: 8] = 8'd127;
      else word[8*lane +: 8] = 8'(total / 64);
    end
    return word;
  endfunction

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic abort_run(string why);
    $display("run stopped at %0t ns: %s", $time, why);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic report_test(string name, bit ok);
    tests_run++;
    if (ok) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: mismatch", name);
    end
  endtask

  task automatic load_bias(logic [31:0] b);
    @(posedge clk);
    #1 bias_we = 1'b1;
    bias_data = b;
    @(posedge clk);
    #1 bias_we = 1'b0;
    cur_bias = b;
  endtask

  // returns at the negedge before the edge that takes the beat
  task automatic wait_accept();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!in_ready) begin
      @(posedge clk);
      cycles++;
      if (cycles > 500) abort_run("in_ready never came back high");
      @(negedge clk);
    end
  endtask

  task automatic send_rows(int count);
    int gaps;
    int cycles;
    for (int r = 0; r < count; r++) begin
      if (row_bias[r] !== cur_bias) begin
        @(posedge clk);
        #1 in_valid = 1'b0;
        cycles = 0;
        while (rcvd != r) begin // drain before new bias
          @(posedge clk);
          cycles++;
          if (cycles > 1000) abort_run("pipeline did not drain before a bias change");
        end
        load_bias(row_bias[r]);
      end
      for (int k = 0; k < row_len[r]; k++) begin
        gaps = row_rnd[r] ? int'($urandom % 3) : 0;
        repeat (gaps) begin
          @(posedge clk);
          #1 in_valid = 1'b0;
        end
        @(posedge clk);
        #1 in_valid = 1'b1;
        in_feat    = row_feat[r][8*k +: 8];
        in_weights = beat_weights(r, k);
        in_first   = (k == 0);
        in_last    = (k == row_len[r] - 1);
        wait_accept();
      end
    end
    @(posedge clk);
    #1 in_valid = 1'b0;
  endtask

  task automatic collect_rows(int count);
    int          cycles;
    bit          got;
    bit          ok;
    logic [31:0] exp;
    for (int r = 0; r < count; r++) begin
      exp    = expected_word(r);
      got    = 1'b0;
      ok     = 1'b1;
      cycles = 0;
      while (!got) begin
        @(posedge clk);
        #1 out_ready = row_rnd[r] ? ($urandom % 4 != 0) : 1'b1;
        @(negedge clk);
        got = out_valid && out_ready;
        cycles++;
        if (!got && cycles > 1000) abort_run("no output word arrived");
      end
      assert (out_data === exp) else begin
        $display("[FAIL] %0t ns: row %0d out_data %h, expected %h", $time, r, out_data, exp);
        ok = 1'b0;
      end
      rcvd++;
      report_test($sformatf("row %0d len %0d", r, row_len[r]), ok);
    end
  endtask

  // single-beat dot product timed from accept edge to out_valid
  task automatic check_latency(int r);
    int          cycles;
    bit          ok;
    logic [31:0] exp;
    ok  = 1'b1;
    exp = expected_word(r);
    @(posedge clk);
    #1 out_ready = 1'b1;
    in_valid   = 1'b1;
    in_feat    = row_feat[r][7:0];
    in_weights = row_w[r];
    in_first   = 1'b1;
    in_last    = 1'b1;
    wait_accept();
    @(posedge clk);
    #1 in_valid = 1'b0;
    cycles = 1;
    @(negedge clk);
    while (!out_valid) begin
      @(posedge clk);
      cycles++;
      if (cycles > 40) abort_run("out_valid never rose in the latency test");
      @(negedge clk);
    end
    assert (cycles == 10) else begin
      $display("[FAIL] %0t ns: latency %0d cycles, expected 10", $time, cycles);
      ok = 1'b0;
    end
    assert (out_data === exp) else begin
      $display("[FAIL] %0t ns: latency word %h, expected %h", $time, out_data, exp);
      ok = 1'b0;
    end
    report_test("latency", ok);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int unused_seed;
    bit reset_ok;
    unused_seed = $urandom(32'hd00b);
    rstn       = 1'b0;
    in_valid   = 1'b0;
    in_feat    = '0;
    in_weights = '0;
    in_first   = 1'b0;
    in_last    = 1'b0;
    bias_we    = 1'b0;
    bias_data  = '0;
    out_ready  = 1'b0; // in_ready then depends on out_valid alone
    // len, features (beat 0 low), weights {l3..l0}, biases {l3..l0}, random
    add_row(1, 72'h80, 32'h80_05_fb_7f, 32'h0, 1'b0); // -128 both ways
    add_row(3, 72'hc0_40_21, 32'h03_fe_10_f0, 32'h0, 1'b0);
    add_row(9, 72'h7f_80_12_ee_33_cd_44_bc_55, 32'h81_0c_f3_20, 32'h0, 1'b0);
    add_row(3, 72'h10_20_30, 32'h04_fc_08_02, 32'h01_10_f8_40, 1'b0);
    add_row(1, 72'h7f, 32'h7f_81_7f_81, 32'h00_00_00_7f, 1'b0);
    add_row(2, 72'h00_00, 32'h00_00_00_00, 32'h7f_80_01_ff, 1'b0); // bias alone
    add_row(4, 72'h9c_27_e3_58, 32'h1f_e2_2d_b7, 32'h08_f8_04_fc, 1'b1);
    add_row(1, 72'h44, 32'hc4_3b_11_ee, 32'h08_f8_04_fc, 1'b1);
    add_row(9, 72'h01_fe_7f_80_33_cc_5a_a5_0f, 32'h12_34_56_78, 32'h08_f8_04_fc, 1'b1);
    add_row(2, 72'h80_80, 32'h80_80_80_80, 32'h08_f8_04_fc, 1'b1);
    add_row(3, 72'h05_fa_6b, 32'h9a_65_c3_3c, 32'h08_f8_04_fc, 1'b1);
    add_row(1, 72'h11, 32'hf0_0f_e1_1e, 32'h08_f8_04_fc, 1'b1);
    add_row(1, 72'h30, 32'h05_06_07_08, 32'h08_f8_04_fc, 1'b0); // latency row
    repeat (2) @(posedge clk);
    #1 rstn = 1'b1;
    @(negedge clk);
    reset_ok = 1'b1;
    assert (out_valid === 1'b0 && in_ready === 1'b1) else begin
      $display("[FAIL] %0t ns: after reset out_valid %b in_ready %b", $time, out_valid,
               in_ready);
      reset_ok = 1'b0;
    end
    report_test("reset state", reset_ok);
    load_bias(row_bias[0]);
    fork
      send_rows(nrows - 1);
      collect_rows(nrows - 1);
    join
    check_latency(nrows - 1);
    $display("%0d tests run, %0d failed", tests_run, tests_failed);
    if (tests_failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+logic
logic/conv_arith_pkg.sv
logic/conv_stream_pkg.sv
logic/cla_adder.sv
logic/mac_lane.sv
logic/operand_feeder.sv
logic/result_packer.sv
logic/conv_mac_array.sv
tests/conv_mac_checker.sv
tests/conv_mac_array_tb.sv

/* Makefile */
TOP = conv_mac_array_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) | awk '{ print } /SIMULATION PASSED/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
